/* rtl/quad_root_pkg.sv */
package quad_root_pkg;

    // input coefficients b and c are signed with one integer bit
    localparam int DEF_DIN_WIDTH = 16;
    localparam int DEF_DIN_POINT = 14;

    // unsigned root; the radicand is twice this width
    localparam int DEF_SQRT_WIDTH = 12;
    localparam int DEF_SQRT_POINT = 9;

    // 16 entries
    localparam int DEF_FIFO_ADDR_WIDTH = 4;

    // register stages between din_valid and disc_valid
    localparam int DISC_LATENCY = 3;

    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_RUN,
        SQ_DONE
    } sqrt_state_e;

endpackage

/* rtl/discriminant_stage.sv */
module discriminant_stage #(
    parameter int DIN_WIDTH  = quad_root_pkg::DEF_DIN_WIDTH,
    parameter int DIN_POINT  = quad_root_pkg::DEF_DIN_POINT,
    parameter int SQRT_WIDTH = quad_root_pkg::DEF_SQRT_WIDTH,
    parameter int SQRT_POINT = quad_root_pkg::DEF_SQRT_POINT
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic signed [DIN_WIDTH-1:0] b,
    input  logic signed [DIN_WIDTH-1:0] c,
    input  logic                        din_valid,
    output logic                        disc_neg,
    output logic [2*SQRT_WIDTH-1:0]     radicand,
    output logic signed [SQRT_WIDTH:0]  b_q,
    output logic                        disc_valid
);
    import quad_root_pkg::*;

    // b*b - 4c needs two guard bits over the plain product at point 2*DIN_POINT
    localparam int DISC_W    = 2 * DIN_WIDTH + 2;
    localparam int RAD_SHIFT = 2 * DIN_POINT - 2 * SQRT_POINT;

    logic signed [DISC_W-1:0]    b_ext;
    logic signed [DISC_W-1:0]    c_ext;
    logic signed [DIN_WIDTH-1:0] b_shift;

    logic signed [DISC_W-1:0]   b_sq_1;
    logic signed [DISC_W-1:0]   c4_1;
    logic signed [SQRT_WIDTH:0] b_q_1;
    logic                       valid_1;

    logic signed [DISC_W-1:0]   diff_2;
    logic signed [SQRT_WIDTH:0] b_q_2;
    logic                       valid_2;

    assign b_ext   = b;
    assign c_ext   = c;
    assign b_shift = b >>> (DIN_POINT - SQRT_POINT);

    // valid chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_1    <= 1'b0;
            valid_2    <= 1'b0;
            disc_valid <= 1'b0;
        end else begin
            valid_1    <= din_valid;
            valid_2    <= valid_1;
            disc_valid <= valid_2;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1 registers b squared and 4c at point 2*DIN_POINT
        b_sq_1 <= b_ext * b_ext;
        c4_1   <= c_ext <<< (DIN_POINT + 2);
        b_q_1  <= b_shift[SQRT_WIDTH:0];
        // stage 2
        diff_2 <= b_sq_1 - c4_1;
        b_q_2  <= b_q_1;
        // stage 3 registers the sign and the floor cast to the radicand format
        disc_neg <= diff_2[DISC_W-1];
        radicand <= diff_2[DISC_W-1] ? '0 : diff_2[RAD_SHIFT +: 2*SQRT_WIDTH];
        b_q      <= b_q_2;
    end

    a_disc_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        disc_valid == $past(din_valid, DISC_LATENCY)
    );

endmodule

/* rtl/sample_fifo.sv */
module sample_fifo #(
    parameter int FIFO_ADDR_WIDTH = quad_root_pkg::DEF_FIFO_ADDR_WIDTH,
    parameter int SQRT_WIDTH      = quad_root_pkg::DEF_SQRT_WIDTH,
    parameter int SKID            = quad_root_pkg::DISC_LATENCY
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_valid,
    input  logic                       wr_neg,
    input  logic [2*SQRT_WIDTH-1:0]    wr_radicand,
    input  logic signed [SQRT_WIDTH:0] wr_b,
    output logic                       fifo_full,
    output logic                       head_neg,
    output logic [2*SQRT_WIDTH-1:0]    head_radicand,
    output logic signed [SQRT_WIDTH:0] head_b,
    output logic                       fifo_empty,
    input  logic                       pop
);

    localparam int DEPTH  = 1 << FIFO_ADDR_WIDTH;
    localparam int CNT_W  = FIFO_ADDR_WIDTH + 1;
    // entry is {neg, radicand, b}
    localparam int WORD_W = 1 + 2 * SQRT_WIDTH + SQRT_WIDTH + 1;

    logic [WORD_W-1:0]          mem [DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       do_pop;

    assign do_pop     = pop && !fifo_empty;
    assign fifo_empty = (count == '0);
    // early full keeps room for every sample still in the discriminant pipe
    assign fifo_full  = (count >= CNT_W'(DEPTH - SKID));

    // first word fall through reads the head straight from the array
    assign {head_neg, head_radicand, head_b} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= {wr_neg, wr_radicand, wr_b};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_valid, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_valid |-> (count != CNT_W'(DEPTH))
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> !fifo_empty
    );

endmodule

/* rtl/iterative_sqrt.sv */
module iterative_sqrt #(
    parameter int SQRT_WIDTH = quad_root_pkg::DEF_SQRT_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fifo_empty,
    input  logic                       head_neg,
    input  logic [2*SQRT_WIDTH-1:0]    head_radicand,
    input  logic signed [SQRT_WIDTH:0] head_b,
    output logic                       pop,
    output logic [SQRT_WIDTH-1:0]      root,
    output logic                       root_neg,
    output logic signed [SQRT_WIDTH:0] root_b,
    output logic                       root_valid
);
    import quad_root_pkg::*;

    // remainder stays below 2*root+1 before the shift in of two radicand bits
    localparam int REM_W = SQRT_WIDTH + 3;
    localparam int CNT_W = $clog2(SQRT_WIDTH);

    sqrt_state_e state;
    sqrt_state_e state_next;

    logic [CNT_W-1:0]           iter;
    logic                       last_iter;
    logic [2*SQRT_WIDTH-1:0]    rad_r;
    logic [REM_W-1:0]           rem_r;
    logic [SQRT_WIDTH-1:0]      q_r;
    logic                       neg_r;
    logic signed [SQRT_WIDTH:0] b_r;

    logic [REM_W-1:0] rem_sh;
    logic [REM_W-1:0] trial_div;
    logic [REM_W:0]   trial;

    assign pop       = (state == SQ_IDLE) && !fifo_empty;
    assign last_iter = (iter == CNT_W'(SQRT_WIDTH - 1));

    // bring down the next two radicand bits and try 4q+1
    assign rem_sh    = {rem_r[REM_W-3:0], rad_r[2*SQRT_WIDTH-1 -: 2]};
    assign trial_div = {1'b0, q_r, 2'b01};
    assign trial     = {1'b0, rem_sh} - {1'b0, trial_div};

    always_comb begin
        state_next = state;
        case (state)
            SQ_IDLE: begin
                if (pop) begin
                    // negative discriminant has nothing to iterate on
                    state_next = head_neg ? SQ_DONE : SQ_RUN;
                end
            end
            SQ_RUN: begin
                if (last_iter) begin
                    state_next = SQ_DONE;
                end
            end
            SQ_DONE: begin
                state_next = SQ_IDLE;
            end
            default: begin
                state_next = SQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SQ_IDLE;
            iter       <= '0;
            root_valid <= 1'b0;
        end else begin
            state      <= state_next;
            iter       <= (state == SQ_RUN) ? iter + 1'b1 : '0;
            root_valid <= (state == SQ_DONE);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rad_r <= head_radicand;
            rem_r <= '0;
            q_r   <= '0;
            neg_r <= head_neg;
            b_r   <= head_b;
        end else if (state == SQ_RUN) begin
            rad_r <= rad_r << 2;
            if (!trial[REM_W]) begin
                rem_r <= trial[REM_W-1:0];
                q_r   <= {q_r[SQRT_WIDTH-2:0], 1'b1};
            end else begin
                // restore by keeping the shifted remainder
                rem_r <= rem_sh;
                q_r   <= {q_r[SQRT_WIDTH-2:0], 1'b0};
            end
        end
        if (state == SQ_DONE) begin
            root     <= q_r;
            root_neg <= neg_r;
            root_b   <= b_r;
        end
    end

    // a positive entry runs every iteration before its result
    a_run_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pop && !head_neg) |-> ##(SQRT_WIDTH + 2) root_valid
    );

    // a negative entry skips the iterations
    a_bypass_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pop && head_neg) |-> ##2 root_valid
    );

endmodule

/* rtl/root_combine.sv */
module root_combine #(
    parameter int SQRT_WIDTH = quad_root_pkg::DEF_SQRT_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [SQRT_WIDTH-1:0]        root,
    input  logic                         root_neg,
    input  logic signed [SQRT_WIDTH:0]   root_b,
    input  logic                         root_valid,
    output logic signed [SQRT_WIDTH+1:0] x1,
    output logic signed [SQRT_WIDTH+1:0] x2,
    output logic                         out_valid,
    output logic                         out_error
);

    // one bit over b_q so that -b plus or minus root cannot wrap
    localparam int OUT_W = SQRT_WIDTH + 2;

    logic signed [OUT_W-1:0] b_ext;
    logic signed [OUT_W-1:0] r_ext;
    logic signed [OUT_W-1:0] neg_b;
    logic signed [OUT_W-1:0] sum_p;
    logic signed [OUT_W-1:0] sum_m;
    logic signed [OUT_W-1:0] half_p;
    logic signed [OUT_W-1:0] half_m;

    assign b_ext = root_b;
    assign r_ext = {2'b00, root};
    assign neg_b = -b_ext;
    assign sum_p = neg_b + r_ext;
    assign sum_m = neg_b - r_ext;

    // halving by arithmetic shift floors toward minus infinity
    assign half_p = sum_p >>> 1;
    assign half_m = sum_m >>> 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_error <= 1'b0;
        end else begin
            out_valid <= root_valid;
            out_error <= root_valid && root_neg;
        end
    end

    always_ff @(posedge clk) begin
        if (root_valid) begin
            x1 <= root_neg ? '0 : half_p;
            x2 <= root_neg ? '0 : half_m;
        end
    end

endmodule

/* rtl/quad_root_top.sv */
module quad_root_top #(
    parameter int DIN_WIDTH       = quad_root_pkg::DEF_DIN_WIDTH,
    parameter int DIN_POINT       = quad_root_pkg::DEF_DIN_POINT,
    parameter int SQRT_WIDTH      = quad_root_pkg::DEF_SQRT_WIDTH,
    parameter int SQRT_POINT      = quad_root_pkg::DEF_SQRT_POINT,
    parameter int FIFO_ADDR_WIDTH = quad_root_pkg::DEF_FIFO_ADDR_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic signed [DIN_WIDTH-1:0]  b,
    input  logic signed [DIN_WIDTH-1:0]  c,
    input  logic                         din_valid,
    output logic                         fifo_full,
    output logic signed [SQRT_WIDTH+1:0] x1,
    output logic signed [SQRT_WIDTH+1:0] x2,
    output logic                         out_valid,
    output logic                         out_error
);
    import quad_root_pkg::*;

    // discriminant pipe to fifo
    logic                       disc_neg;
    logic [2*SQRT_WIDTH-1:0]    radicand;
    logic signed [SQRT_WIDTH:0] b_q;
    logic                       disc_valid;

    // fifo head to sqrt
    logic                       head_neg;
    logic [2*SQRT_WIDTH-1:0]    head_radicand;
    logic signed [SQRT_WIDTH:0] head_b;
    logic                       fifo_empty;
    logic                       pop;

    // sqrt to output stage
    logic [SQRT_WIDTH-1:0]      root;
    logic                       root_neg;
    logic signed [SQRT_WIDTH:0] root_b;
    logic                       root_valid;

    discriminant_stage #(
        .DIN_WIDTH  (DIN_WIDTH),
        .DIN_POINT  (DIN_POINT),
        .SQRT_WIDTH (SQRT_WIDTH),
        .SQRT_POINT (SQRT_POINT)
    ) disc0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .b          (b),
        .c          (c),
        .din_valid  (din_valid),
        .disc_neg   (disc_neg),
        .radicand   (radicand),
        .b_q        (b_q),
        .disc_valid (disc_valid)
    );

    sample_fifo #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH),
        .SQRT_WIDTH      (SQRT_WIDTH),
        .SKID            (DISC_LATENCY)
    ) fifo0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_valid      (disc_valid),
        .wr_neg        (disc_neg),
        .wr_radicand   (radicand),
        .wr_b          (b_q),
        .fifo_full     (fifo_full),
        .head_neg      (head_neg),
        .head_radicand (head_radicand),
        .head_b        (head_b),
        .fifo_empty    (fifo_empty),
        .pop           (pop)
    );

    iterative_sqrt #(
        .SQRT_WIDTH (SQRT_WIDTH)
    ) sqrt0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .fifo_empty    (fifo_empty),
        .head_neg      (head_neg),
        .head_radicand (head_radicand),
        .head_b        (head_b),
        .pop           (pop),
        .root          (root),
        .root_neg      (root_neg),
        .root_b        (root_b),
        .root_valid    (root_valid)
    );

    root_combine #(
        .SQRT_WIDTH (SQRT_WIDTH)
    ) comb0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .root       (root),
        .root_neg   (root_neg),
        .root_b     (root_b),
        .root_valid (root_valid),
        .x1         (x1),
        .x2         (x2),
        .out_valid  (out_valid),
        .out_error  (out_error)
    );

endmodule

/* tests/quad_root_model.svh */
`ifndef QUAD_ROOT_MODEL_SVH
`define QUAD_ROOT_MODEL_SVH

// reference arithmetic in 64-bit integers where every narrowing is a floor

function automatic longint floor_div(input longint num, input longint den);
    longint q;
    q = num / den;
    // integer division truncates toward zero so a negative quotient is pulled down
    if ((num % den != 0) && ((num < 0) != (den < 0))) begin
        q = q - 1;
    end
    return q;
endfunction

// b moved from DIN_POINT to SQRT_POINT fraction bits
function automatic longint quantize_b(input int bv);
    return floor_div(longint'(bv), longint'(1) << (DEF_DIN_POINT - DEF_SQRT_POINT));
endfunction

// b*b - 4c with 2*DIN_POINT fraction bits
function automatic longint discriminant(input int bv, input int cv);
    longint bl;
    longint cl;
    bl = bv;
    cl = cv;
    return bl * bl - 4 * cl * (longint'(1) << DEF_DIN_POINT);
endfunction

// radicand has 2*SQRT_POINT fraction bits, zero for a negative discriminant
function automatic longint radicand_of(input int bv, input int cv);
    longint d;
    d = discriminant(bv, cv);
    if (d < 0) begin
        return 0;
    end
    return floor_div(d, longint'(1) << (2 * (DEF_DIN_POINT - DEF_SQRT_POINT)));
endfunction

// binary search keeping lo*lo <= n < hi*hi
function automatic longint isqrt_floor(input longint n);
    longint lo;
    longint hi;
    longint mid;
    lo = 0;
    hi = longint'(1) << DEF_SQRT_WIDTH;
    while (hi - lo > 1) begin
        mid = (lo + hi) / 2;
        if (mid * mid <= n) begin
            lo = mid;
        end else begin
            hi = mid;
        end
    end
    return lo;
endfunction

`endif

/* tests/tb_quad_root.sv */
module tb_quad_root;
    timeunit 1ns;
    timeprecision 1ps;

    import quad_root_pkg::*;

    localparam int DIN_W         = DEF_DIN_WIDTH;
    localparam int OUT_W         = DEF_SQRT_WIDTH + 2;
    localparam int C_MIN         = -(1 << (DIN_W - 1));
    localparam int C_MAX         = (1 << (DIN_W - 1)) - 1;
    localparam int FULL_TIMEOUT  = 500;
    localparam int DRAIN_TIMEOUT = 2000;

    typedef struct packed {
        int b;
        int c;
        int x1;
        int x2;
        bit err;
    } expect_t;

    `include "quad_root_model.svh"

    logic                    clk;
    logic                    rst_n;
    logic signed [DIN_W-1:0] b;
    logic signed [DIN_W-1:0] c;
    logic                    din_valid;
    logic                    fifo_full;
    logic signed [OUT_W-1:0] x1;
    logic signed [OUT_W-1:0] x2;
    logic                    out_valid;
    logic                    out_error;

    integer  seed;
    expect_t pending[$];
    expect_t head_exp;
    int      errors = 0;
    int      accepted = 0;
    int      results_seen = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    bit      aborted = 1'b0;
    bit      full_seen = 1'b0;

    quad_root_top #(
        .DIN_WIDTH       (DEF_DIN_WIDTH),
        .DIN_POINT       (DEF_DIN_POINT),
        .SQRT_WIDTH      (DEF_SQRT_WIDTH),
        .SQRT_POINT      (DEF_SQRT_POINT),
        .FIFO_ADDR_WIDTH (DEF_FIFO_ADDR_WIDTH)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .b         (b),
        .c         (c),
        .din_valid (din_valid),
        .fifo_full (fifo_full),
        .x1        (x1),
        .x2        (x2),
        .out_valid (out_valid),
        .out_error (out_error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rand_coef();
        logic signed [DIN_W-1:0] r;
        r = DIN_W'($random(seed));
        return int'(r);
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    // largest c that keeps b*b - 4c non-negative
    function automatic int max_real_c(input int bv);
        return int'(floor_div(longint'(bv) * bv, longint'(1) << (DEF_DIN_POINT + 2)));
    endfunction

    function automatic expect_t predict(input int bv, input int cv);
        expect_t e;
        longint  nb;
        longint  r;
        e.b = bv;
        e.c = cv;
        nb  = -quantize_b(bv);
        if (discriminant(bv, cv) < 0) begin
            e.err = 1'b1;
            e.x1  = 0;
            e.x2  = 0;
        end else begin
            r     = isqrt_floor(radicand_of(bv, cv));
            e.err = 1'b0;
            e.x1  = int'(floor_div(nb + r, 2));
            e.x2  = int'(floor_div(nb - r, 2));
        end
        return e;
    endfunction

    task automatic check_result(input expect_t e);
        if (out_error !== e.err) begin
            $display("Mismatch at %0t: out_error %0b, expected %0b for b=%0d c=%0d",
                     $time, out_error, e.err, e.b, e.c);
            errors++;
        end
        if (x1 !== e.x1) begin
            $display("Mismatch at %0t: x1 %0d, expected %0d for b=%0d c=%0d",
                     $time, x1, e.x1, e.b, e.c);
            errors++;
        end
        if (x2 !== e.x2) begin
            $display("Mismatch at %0t: x2 %0d, expected %0d for b=%0d c=%0d",
                     $time, x2, e.x2, e.b, e.c);
            errors++;
        end
    endtask

    // outputs are sampled mid cycle by the scoreboard
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            results_seen++;
            if (pending.size() == 0) begin
                $display("result at %0t arrived with no sample outstanding", $time);
                errors++;
            end else begin
                head_exp = pending.pop_front();
                check_result(head_exp);
            end
        end
        if (fifo_full) begin
            full_seen = 1'b1;
        end
    end

    task automatic idle_cycles(input int n);
        din_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic send_sample(input int bv, input int cv);
        int n;
        n = 0;
        if (!aborted) begin
            while (fifo_full && n < FULL_TIMEOUT) begin
                din_valid = 1'b0;
                @(negedge clk);
                n++;
            end
            if (fifo_full) begin
                $display("timeout at %0t: fifo_full stayed high for %0d cycles",
                         $time, FULL_TIMEOUT);
                errors++;
                aborted   = 1'b1;
                din_valid = 1'b0;
            end else begin
                b         = bv[DIN_W-1:0];
                c         = cv[DIN_W-1:0];
                din_valid = 1'b1;
                pending.push_back(predict(bv, cv));
                accepted++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        din_valid = 1'b0;
        while (pending.size() != 0 && n < DRAIN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pending.size() != 0) begin
            $display("timeout at %0t: %0d results still missing after %0d cycles",
                     $time, pending.size(), DRAIN_TIMEOUT);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int err0);
        if (errors == err0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - err0);
        end
    endtask

    task automatic idle_after_reset();
        int err0;
        err0 = errors;
        if (out_valid !== 1'b0 || out_error !== 1'b0 || fifo_full !== 1'b0) begin
            $display("Mismatch at %0t: out_valid=%0b out_error=%0b fifo_full=%0b after reset",
                     $time, out_valid, out_error, fifo_full);
            errors++;
        end
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("Mismatch at %0t: out_valid high with no input", $time);
                errors++;
            end
        end
        finish_test("reset and idle", err0);
    endtask

    task automatic random_real_roots();
        int err0;
        int bv;
        int cmax;
        err0 = errors;
        for (int i = 0; i < 300 && !aborted; i++) begin
            bv   = rand_coef();
            cmax = max_real_c(bv);
            idle_cycles(rand_below(3));
            send_sample(bv, C_MIN + rand_below(cmax - C_MIN + 1));
        end
        wait_drain();
        finish_test("random real roots", err0);
    endtask

    task automatic negative_disc_mix();
        int err0;
        int bv;
        int cmax;
        err0 = errors;
        for (int i = 0; i < 120 && !aborted; i++) begin
            bv   = rand_coef();
            cmax = max_real_c(bv);
            idle_cycles(rand_below(3));
            if (rand_below(2) == 0) begin
                send_sample(bv, cmax + 1 + rand_below(C_MAX - cmax));
            end else begin
                send_sample(bv, C_MIN + rand_below(cmax - C_MIN + 1));
            end
        end
        wait_drain();
        finish_test("negative discriminant mix", err0);
    endtask

    task automatic edge_value_samples();
        int err0;
        err0 = errors;
        // c = 0 puts one root at zero
        send_sample(16384, 0);
        send_sample(-16384, 0);
        send_sample(4660, 0);
        send_sample(-1, 0);
        send_sample(1, 0);
        send_sample(32767, 0);
        send_sample(-32768, 0);
        send_sample(0, 0);
        // b*b = 4c gives a double root
        send_sample(16384, 4096);
        send_sample(-16384, 4096);
        send_sample(1792, 49);
        send_sample(-256, 1);
        send_sample(-32768, 16384);
        // b = -2 and c = -2
        send_sample(-32768, -32768);
        wait_drain();
        finish_test("edge values", err0);
    endtask

    task automatic burst_with_backpressure();
        int err0;
        int acc0;
        int res0;
        err0      = errors;
        acc0      = accepted;
        res0      = results_seen;
        full_seen = 1'b0;
        for (int i = 0; i < 200 && !aborted; i++) begin
            send_sample(rand_coef(), rand_coef());
        end
        wait_drain();
        // trailing window to catch duplicated results
        idle_cycles(30);
        if (results_seen - res0 != accepted - acc0) begin
            $display("Mismatch at %0t: %0d results for %0d accepted samples",
                     $time, results_seen - res0, accepted - acc0);
            errors++;
        end
        if (pending.size() != 0) begin
            $display("%0d expected results were never produced", pending.size());
            errors++;
        end
        if (!full_seen) begin
            $display("fifo_full never went high during the burst");
            errors++;
        end
        finish_test("burst with back-pressure", err0);
    endtask

    initial begin
        seed      = 32'h92746d40;
        rst_n     = 1'b0;
        b         = '0;
        c         = '0;
        din_valid = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        idle_after_reset();
        if (!aborted) random_real_roots();
        if (!aborted) negative_disc_mix();
        if (!aborted) edge_value_samples();
        if (!aborted) burst_with_backpressure();

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+tests
rtl/quad_root_pkg.sv
rtl/discriminant_stage.sv
rtl/sample_fifo.sv
rtl/iterative_sqrt.sv
rtl/root_combine.sv
rtl/quad_root_top.sv
tests/tb_quad_root.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the quadratic root testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_quad_root \
    -o sim_quad_root

output=$(./obj_dir/sim_quad_root)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
else
    echo "simulation did not report a pass" >&2
    exit 1
fi
